// ==== smc_consts.svh ====
`ifndef SMC_CONSTS_SVH
`define SMC_CONSTS_SVH

// --------------------------------------------------------------------------
// External access timing profile, in hclk cycles
// --------------------------------------------------------------------------
`define SMC_CSLE_CYCLES 1    // Chip select leading phase
`define SMC_WS_CYCLES   2    // Strobe (wait-state) phase
`define SMC_CSTE_CYCLES 1    // Chip select trailing phase

// External bus
`define SMC_EMI_BYTES   2    // 16-bit SRAM bank

// --------------------------------------------------------------------------
// AHB encodings
// --------------------------------------------------------------------------
`define SMC_SIZE_BYTE   2'd0 // hsize byte
`define SMC_SIZE_HALF   2'd1 // hsize halfword
`define SMC_SIZE_WORD   2'd2 // hsize word

// htrans bit set for NONSEQ and SEQ
`define SMC_TRANS_NONSEQ 1

`endif

// ==== smc_pkg.sv ====
package smc_pkg;

  // --------------------------------------------------------------------------
  // Bus and datapath widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] haddr_t;     // AHB address
  typedef logic [31:0] hdata_t;     // AHB data
  typedef logic [15:0] emi_data_t;  // External data bus
  typedef logic [1:0]  emi_be_t;    // Byte enables, active low
  typedef logic [1:0]  xfer_size_t; // hsize[1:0]

  // Timing counters
  typedef logic [1:0]  phase_count_t; // CSLE / CSTE
  typedef logic [7:0]  ws_count_t;    // Wait states

  // Sub-access index within one AHB transfer
  typedef logic        acc_num_t;

  // --------------------------------------------------------------------------
  // Access state machine
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    SMC_IDLE = 3'd0, // Waiting for a transfer
    SMC_LE   = 3'd1, // Chip select leading edge
    SMC_RW   = 3'd2, // Strobe phase
    SMC_TE   = 3'd3, // Chip select trailing edge
    SMC_DONE = 3'd4  // Transfer complete
  } smc_state_e;

endpackage

// ==== smc_ahb_if.sv ====
`timescale 1ns/1ps

`include "smc_consts.svh"

module smc_ahb_if (
  input  logic                 hclk,
  input  logic                 rst_n,
  input  logic                 hsel,          // Slave select
  input  logic [1:0]           htrans,        // Transfer type
  input  logic                 hwrite,        // 1 = write
  input  logic [2:0]           hsize,         // Transfer size
  input  smc_pkg::haddr_t      haddr,
  input  smc_pkg::hdata_t      hwdata,
  input  logic                 hready,        // Muxed bus ready
  input  smc_pkg::hdata_t      read_data,     // Assembled by MAC
  input  logic                 transfer_done, // Last access of last sub-access
  input  logic                 smc_idle,
  output logic                 new_access,    // Accepted this cycle
  output smc_pkg::haddr_t      addr,
  output smc_pkg::xfer_size_t  xfer_size,
  output logic                 n_read,        // Active-low read flag
  output smc_pkg::hdata_t      write_data,
  output smc_pkg::hdata_t      smc_hrdata,
  output logic                 smc_hready
);

  import smc_pkg::*;

  logic data_phase; // AHB data phase of an accepted transfer

  // --------------------------------------------------------------------------
  // Transfer qualification
  // --------------------------------------------------------------------------
  // Own hready folded in so a stalled master cannot start a second access
  assign new_access = hsel && htrans[`SMC_TRANS_NONSEQ] && hready && smc_hready;

  // Control state
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      n_read     <= 1'b1;
      data_phase <= 1'b0;
    end else begin
      data_phase <= new_access; // hwdata valid one cycle after address
      if (new_access) begin
        n_read <= hwrite; // Low for reads
      end
    end
  end

  // Address phase fields and write data
  always_ff @(posedge hclk) begin
    if (new_access) begin
      addr      <= haddr;
      xfer_size <= xfer_size_t'(hsize[1:0]); // Max is word
    end
    if (data_phase && n_read) begin
      write_data <= hwdata; // Held until the next write
    end
  end

  // --------------------------------------------------------------------------
  // Ready to the bus
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_hready <= 1'b1;
    end else if (new_access) begin
      smc_hready <= 1'b0;             // Stall from the next cycle
    end else if (transfer_done || smc_idle) begin
      smc_hready <= 1'b1;             // Release after the last access
    end
  end

  // Read data only shown once the transfer has finished
  assign smc_hrdata = (smc_hready && !n_read) ? read_data : '0;

endmodule

// ==== smc_counter.sv ====
`timescale 1ns/1ps

`include "smc_consts.svh"

module smc_counter (
  input  logic                  hclk,
  input  logic                  rst_n,
  input  logic                  le_enable, // In leading phase
  input  logic                  ws_enable, // In strobe phase
  input  logic                  te_enable, // In trailing phase
  output smc_pkg::phase_count_t le_count,
  output smc_pkg::ws_count_t    ws_count,
  output smc_pkg::phase_count_t te_count
);

  import smc_pkg::*;

  // Counts run down to zero, so each phase lasts its reload plus one
  localparam phase_count_t LE_RELOAD = phase_count_t'(`SMC_CSLE_CYCLES - 1);
  localparam ws_count_t    WS_RELOAD = ws_count_t'(`SMC_WS_CYCLES - 1);
  localparam phase_count_t TE_RELOAD = phase_count_t'(`SMC_CSTE_CYCLES - 1);

  // --------------------------------------------------------------------------
  // Phase down-counters
  // --------------------------------------------------------------------------
  // Preloaded while the phase is inactive, so the first cycle after the
  // enable rises already sees the full count
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      le_count <= LE_RELOAD;
      ws_count <= WS_RELOAD;
      te_count <= TE_RELOAD;
    end else begin
      if (!le_enable) begin
        le_count <= LE_RELOAD;
      end else if (le_count != '0) begin
        le_count <= le_count - 1'b1;
      end

      if (!ws_enable) begin
        ws_count <= WS_RELOAD;
      end else if (ws_count != '0) begin
        ws_count <= ws_count - 1'b1; // Wait states
      end

      if (!te_enable) begin
        te_count <= TE_RELOAD;
      end else if (te_count != '0) begin
        te_count <= te_count - 1'b1;
      end
    end
  end

endmodule

// ==== smc_state.sv ====
`timescale 1ns/1ps

module smc_state (
  input  logic                  hclk,
  input  logic                  rst_n,
  input  logic                  new_access,    // From AHB interface
  input  logic                  transfer_done, // From MAC
  input  smc_pkg::phase_count_t le_count,
  input  smc_pkg::ws_count_t    ws_count,
  input  smc_pkg::phase_count_t te_count,
  output smc_pkg::smc_state_e   state,
  output logic                  le_enable,
  output logic                  ws_enable,
  output logic                  te_enable,
  output logic                  access_done,   // End of each access
  output logic                  latch_data,    // Last strobe cycle at pins
  output logic                  smc_idle
);

  import smc_pkg::*;

  smc_state_e next_state;

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      SMC_IDLE: begin
        if (new_access) begin
          next_state = SMC_LE;
        end
      end
      SMC_LE: begin
        if (le_count == '0) begin
          next_state = SMC_RW;
        end
      end
      SMC_RW: begin
        if (ws_count == '0) begin
          next_state = SMC_TE;
        end
      end
      SMC_TE: begin
        if (te_count == '0) begin
          // Back to LE for the second half of a word
          next_state = transfer_done ? SMC_DONE : SMC_LE;
        end
      end
      SMC_DONE: begin
        // Master may issue the next transfer as soon as ready returns
        next_state = new_access ? SMC_LE : SMC_IDLE;
      end
      default: next_state = SMC_IDLE;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state <= SMC_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------------------------------
  // Phase enables and status
  // --------------------------------------------------------------------------
  assign le_enable   = (state == SMC_LE);
  assign ws_enable   = (state == SMC_RW);
  assign te_enable   = (state == SMC_TE);
  assign access_done = (state == SMC_TE) && (te_count == '0);
  assign smc_idle    = (state == SMC_IDLE);

  // External strobes lag the state by one cycle, so the last pin strobe
  // cycle is the one after the final RW cycle
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      latch_data <= 1'b0;
    end else begin
      latch_data <= (state == SMC_RW) && (ws_count == '0);
    end
  end

endmodule

// ==== smc_mac.sv ====
`timescale 1ns/1ps

`include "smc_consts.svh"

module smc_mac (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                new_access,
  input  logic                access_done,   // One pulse per external access
  input  logic                latch_data,    // Sample data_smc
  input  smc_pkg::xfer_size_t xfer_size,
  input  smc_pkg::haddr_t     addr,
  input  smc_pkg::hdata_t     write_data,
  input  smc_pkg::emi_data_t  data_smc,      // SRAM read data
  output smc_pkg::acc_num_t   acc_num,       // Current sub-access
  output logic                transfer_done,
  output smc_pkg::hdata_t     read_data,
  output smc_pkg::emi_data_t  emi_wdata
);

  import smc_pkg::*;

  acc_num_t last_acc; // Index of final sub-access
  logic     hw_lane;  // AHB halfword lane of this access
  logic     is_byte;

  // Word needs 4 / EMI_BYTES accesses, narrower transfers just one
  assign last_acc = (xfer_size == `SMC_SIZE_WORD) ? acc_num_t'((4 / `SMC_EMI_BYTES) - 1)
                                                  : acc_num_t'(0);
  assign transfer_done = access_done && (acc_num == last_acc);

  // Word accesses are aligned, so addr[1] is zero for them
  assign hw_lane = addr[1] | acc_num;
  assign is_byte = (xfer_size == `SMC_SIZE_BYTE);

  // --------------------------------------------------------------------------
  // Sub-access counter
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      acc_num <= '0;
    end else if (new_access) begin
      acc_num <= '0;
    end else if (access_done) begin
      acc_num <= transfer_done ? acc_num_t'(0) : acc_num + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Read assembly
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (new_access) begin
      read_data <= '0; // Unaccessed lanes read zero
    end else if (latch_data) begin
      if (hw_lane) begin
        if (!is_byte || !addr[0]) read_data[23:16] <= data_smc[7:0];
        if (!is_byte || addr[0])  read_data[31:24] <= data_smc[15:8];
      end else begin
        if (!is_byte || !addr[0]) read_data[7:0]   <= data_smc[7:0];
        if (!is_byte || addr[0])  read_data[15:8]  <= data_smc[15:8];
      end
    end
  end

  // Write lane steering, byte enables pick the byte inside it
  assign emi_wdata = hw_lane ? write_data[31:16] : write_data[15:0];

endmodule

// ==== smc_emi.sv ====
`timescale 1ns/1ps

`include "smc_consts.svh"

module smc_emi (
  input  logic                hclk,
  input  logic                rst_n,
  input  smc_pkg::smc_state_e state,
  input  logic                latch_data,
  input  logic                n_read,
  input  smc_pkg::haddr_t     addr,
  input  smc_pkg::xfer_size_t xfer_size,
  input  smc_pkg::acc_num_t   acc_num,
  input  smc_pkg::emi_data_t  emi_wdata,
  output smc_pkg::haddr_t     smc_addr,     // External address
  output smc_pkg::emi_data_t  smc_data,     // External write data
  output smc_pkg::emi_be_t    smc_n_be,     // Byte enables
  output logic                smc_n_cs,     // Chip select
  output logic                smc_n_rd,     // Read strobe
  output smc_pkg::emi_be_t    smc_n_we,     // Write strobes
  output logic                smc_n_wr,     // Write enable
  output logic                smc_n_ext_oe, // Data driver enable
  output logic                smc_busy
);

  import smc_pkg::*;

  logic    active;   // LE, RW or TE
  logic    strobe;   // RW
  emi_be_t n_be;     // Enables for the current access
  emi_be_t n_we_nxt;
  haddr_t  base;

  assign active = (state == SMC_LE) || (state == SMC_RW) || (state == SMC_TE);
  assign strobe = (state == SMC_RW);

  // --------------------------------------------------------------------------
  // Address and byte enables
  // --------------------------------------------------------------------------
  assign base = {addr[31:1], 1'b0}; // Halfword aligned
  assign n_be = (xfer_size == `SMC_SIZE_BYTE) ? (addr[0] ? 2'b01 : 2'b10)
                                              : 2'b00;

  // Write strobes follow the enables during the strobe phase
  assign n_we_nxt = (strobe && n_read) ? n_be : 2'b11;

  // Address and data pins, no reset needed
  always_ff @(posedge hclk) begin
    smc_addr <= base + haddr_t'(acc_num) * `SMC_EMI_BYTES; // Next halfword
    smc_data <= emi_wdata;
  end

  // --------------------------------------------------------------------------
  // Selects and strobes, one cycle behind the state
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 2'b11;
      smc_n_rd     <= 1'b1;
      smc_n_we     <= 2'b11;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_cs     <= !active;
      smc_n_be     <= active ? n_be : 2'b11;
      // Read strobe held low until the MAC has sampled the data
      smc_n_rd     <= !(!n_read && (strobe || (!smc_n_rd && !latch_data)));
      smc_n_we     <= n_we_nxt;
      smc_n_wr     <= &n_we_nxt;
      smc_n_ext_oe <= !(active && n_read); // Drive bus on writes only
    end
  end

  // Status to the system, not a pin
  assign smc_busy = (state != SMC_IDLE);

endmodule

// ==== smc_lite.sv ====
`timescale 1ns/1ps

module smc_lite (
  input  logic                hclk,
  input  logic                rst_n,
  // AHB-lite slave
  input  logic                hsel,
  input  logic [1:0]          htrans,
  input  logic                hwrite,
  input  logic [2:0]          hsize,
  input  smc_pkg::haddr_t     haddr,
  input  smc_pkg::hdata_t     hwdata,
  input  logic                hready,
  output smc_pkg::hdata_t     smc_hrdata,
  output logic                smc_hready,
  // External memory interface
  input  smc_pkg::emi_data_t  data_smc,
  output smc_pkg::haddr_t     smc_addr,
  output smc_pkg::emi_data_t  smc_data,
  output smc_pkg::emi_be_t    smc_n_be,
  output logic                smc_n_cs,
  output logic                smc_n_rd,
  output smc_pkg::emi_be_t    smc_n_we,
  output logic                smc_n_wr,
  output logic                smc_n_ext_oe,
  output logic                smc_busy
);

  import smc_pkg::*;

  // --------------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------------
  logic         new_access, n_read_q;
  haddr_t       addr;
  xfer_size_t   xfer_size;
  hdata_t       write_data, read_data;
  phase_count_t le_count, te_count;
  ws_count_t    ws_count;
  smc_state_e   state;
  logic         le_enable, ws_enable, te_enable;
  logic         access_done, latch_data, smc_idle, transfer_done;
  acc_num_t     acc_num;
  emi_data_t    emi_wdata;

  smc_ahb_if i_ahb_if (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel), .htrans(htrans), .hwrite(hwrite),
    .hsize(hsize), .haddr(haddr), .hwdata(hwdata), .hready(hready),
    .read_data(read_data), .transfer_done(transfer_done), .smc_idle(smc_idle),
    .new_access(new_access), .addr(addr), .xfer_size(xfer_size), .n_read(n_read_q),
    .write_data(write_data), .smc_hrdata(smc_hrdata), .smc_hready(smc_hready)
  );

  smc_counter i_counter (
    .hclk(hclk), .rst_n(rst_n), .le_enable(le_enable), .ws_enable(ws_enable),
    .te_enable(te_enable), .le_count(le_count), .ws_count(ws_count), .te_count(te_count)
  );

  smc_state i_state (
    .hclk(hclk), .rst_n(rst_n), .new_access(new_access), .transfer_done(transfer_done),
    .le_count(le_count), .ws_count(ws_count), .te_count(te_count), .state(state),
    .le_enable(le_enable), .ws_enable(ws_enable), .te_enable(te_enable),
    .access_done(access_done), .latch_data(latch_data), .smc_idle(smc_idle)
  );

  smc_mac i_mac (
    .hclk(hclk), .rst_n(rst_n), .new_access(new_access), .access_done(access_done),
    .latch_data(latch_data), .xfer_size(xfer_size), .addr(addr),
    .write_data(write_data), .data_smc(data_smc), .acc_num(acc_num),
    .transfer_done(transfer_done), .read_data(read_data), .emi_wdata(emi_wdata)
  );

  smc_emi i_emi (
    .hclk(hclk), .rst_n(rst_n), .state(state), .latch_data(latch_data),
    .n_read(n_read_q), .addr(addr), .xfer_size(xfer_size), .acc_num(acc_num),
    .emi_wdata(emi_wdata), .smc_addr(smc_addr), .smc_data(smc_data),
    .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
    .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr), .smc_n_ext_oe(smc_n_ext_oe),
    .smc_busy(smc_busy)
  );

endmodule

// ==== smc_checker.sv ====
`timescale 1ns/1ps

module smc_checker (
  input logic             hclk,
  input logic             rst_n,
  input logic             smc_n_cs,
  input logic             smc_n_rd,
  input smc_pkg::emi_be_t smc_n_we,
  input logic             smc_n_wr,
  input logic             smc_n_ext_oe,
  input logic             smc_hready,
  input logic             smc_busy
);

  int violation_count = 0; // Assertion failures so far

  // --------------------------------------------------------------------------
  // External strobe rules
  // --------------------------------------------------------------------------
  // Read and write strobes never overlap
  assert property (@(posedge hclk) disable iff (!rst_n) smc_n_rd || smc_n_wr)
    else begin
      violation_count++;
      $error("smc_n_rd and smc_n_wr low in the same cycle");
    end

  // Strobes only inside the chip select window
  assert property (@(posedge hclk) disable iff (!rst_n)
                   smc_n_cs |-> (smc_n_rd && smc_n_wr && (&smc_n_we)))
    else begin
      violation_count++;
      $error("strobe active while smc_n_cs is high");
    end

  assert property (@(posedge hclk) disable iff (!rst_n) !smc_n_ext_oe |-> smc_n_rd)
    else begin
      violation_count++;
      $error("smc_n_ext_oe low during a read strobe"); // Bus contention
    end

  // Stalled bus means a busy controller
  assert property (@(posedge hclk) disable iff (!rst_n) !smc_hready |-> smc_busy)
    else begin
      violation_count++;
      $error("smc_hready low while smc_busy is low");
    end

endmodule

// ==== tb_smc_lite.sv ====
`timescale 1ns/1ps

`include "smc_consts.svh"

module tb_smc_lite;

  import smc_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 5;
  localparam int RNG_SEED    = 39450;
  localparam int NUM_TESTS   = 5;
  localparam int XFER_BUDGET = 20;  // Transfers allowed per test
  localparam int XFER_CYCLES = 40;  // Cycles allowed per transfer
  localparam int WATCHDOG_NS = NUM_TESTS * XFER_BUDGET * XFER_CYCLES * CLK_PERIOD;
  localparam int SRAM_WORDS  = 256; // 512 bytes, indexed by smc_addr[8:1]
  localparam int RAND_PAIRS  = 20;

  logic        hclk;
  logic        rst_n;
  logic        hsel;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [2:0]  hsize;
  haddr_t      haddr;
  hdata_t      hwdata;
  logic        hready;
  hdata_t      smc_hrdata;
  logic        smc_hready;
  emi_data_t   data_smc;
  haddr_t      smc_addr;
  emi_data_t   smc_data;
  logic [1:0]  smc_n_be;
  logic        smc_n_cs;
  logic        smc_n_rd;
  logic [1:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  emi_data_t   sram [0:SRAM_WORDS-1];   // External SRAM model
  emi_data_t   shadow [0:SRAM_WORDS-1]; // Expected memory contents
  logic [1:0]  strobe_be = 2'b11;       // Byte enables at the end of the last write
  int          error_count = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;

  smc_lite UUT (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel), .htrans(htrans), .hwrite(hwrite),
    .hsize(hsize), .haddr(haddr), .hwdata(hwdata), .hready(hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .data_smc(data_smc),
    .smc_addr(smc_addr), .smc_data(smc_data), .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs),
    .smc_n_rd(smc_n_rd), .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr),
    .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy)
  );

  bind smc_lite smc_checker u_smc_checker (
    .hclk(hclk), .rst_n(rst_n), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
    .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr), .smc_n_ext_oe(smc_n_ext_oe),
    .smc_hready(smc_hready), .smc_busy(smc_busy)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // --------------------------------------------------------------------------
  // SRAM model
  // --------------------------------------------------------------------------
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? sram[smc_addr[8:1]] : 'z;

  always @(posedge smc_n_we[0]) begin
    if (rst_n === 1'b1 && smc_n_cs === 1'b0) sram[smc_addr[8:1]][7:0] <= smc_data[7:0];
  end

  always @(posedge smc_n_we[1]) begin
    if (rst_n === 1'b1 && smc_n_cs === 1'b0) sram[smc_addr[8:1]][15:8] <= smc_data[15:8];
  end

  // Enables and bus driver as the SRAM sees them when a write ends
  always @(posedge smc_n_wr) begin
    if (rst_n === 1'b1) begin
      strobe_be = smc_n_be;
      compare_bit("smc_n_ext_oe", smc_n_ext_oe, 1'b0);
    end
  end

  function automatic emi_data_t fill_value(int idx);
    return emi_data_t'(idx * 32'h9E37 + 32'h5A3C); // All index bits matter
  endfunction

  // Right-aligned value moved onto the AHB byte lanes
  function automatic hdata_t bus_lanes(haddr_t a, logic [2:0] size, hdata_t v);
    case (size[1:0])
      `SMC_SIZE_BYTE: return hdata_t'(v[7:0]) << (8 * a[1:0]);
      `SMC_SIZE_HALF: return hdata_t'(v[15:0]) << (16 * a[1]);
      default:        return v;
    endcase
  endfunction

  task automatic shadow_write(input haddr_t a, input logic [2:0] size, input hdata_t lanes);
    int idx;
    idx = int'(a[8:1]);
    case (size[1:0])
      `SMC_SIZE_BYTE: shadow[idx][8*a[0] +: 8] = lanes[8*a[1:0] +: 8];
      `SMC_SIZE_HALF: shadow[idx] = lanes[16*a[1] +: 16];
      default: begin
        shadow[idx]     = lanes[15:0];  // Low half at A
        shadow[idx + 1] = lanes[31:16]; // High half at A+2
      end
    endcase
  endtask

  function automatic hdata_t expected_read(haddr_t a, logic [2:0] size);
    int     idx;
    hdata_t r;
    idx = int'(a[8:1]);
    r   = '0; // Unused lanes read zero
    case (size[1:0])
      `SMC_SIZE_BYTE: r[8*a[1:0] +: 8] = shadow[idx][8*a[0] +: 8];
      `SMC_SIZE_HALF: r[16*a[1] +: 16] = shadow[idx];
      default:        r = {shadow[idx + 1], shadow[idx]};
    endcase
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic compare_data(input string name, input hdata_t got, input hdata_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic compare_half(input string name, input emi_data_t got, input emi_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (error_count == start_errors) begin
      tests_ok++;
      $display("test %-18s ok", name);
    end else begin
      tests_bad++;
      $display("test %-18s %0d errors", name, error_count - start_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // AHB master
  // --------------------------------------------------------------------------
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (smc_hready !== 1'b1 && waited < XFER_CYCLES) begin
      @(negedge hclk);
      waited++;
    end
    if (smc_hready !== 1'b1) begin
      $display("timeout at %0t ns: smc_hready stayed low for %0d cycles", $time, waited);
      error_count++;
    end
  endtask

  task automatic ahb_write(input haddr_t a, input logic [2:0] size, input hdata_t data);
    @(negedge hclk);
    hsel   = 1'b1;  // Address phase
    htrans = 2'b10; // NONSEQ
    hwrite = 1'b1;
    hsize  = size;
    haddr  = a;
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = 2'b00;
    hwdata = data;  // Data phase
    wait_ready();
  endtask

  task automatic ahb_read(input haddr_t a, input logic [2:0] size, output hdata_t data);
    @(negedge hclk);
    hsel   = 1'b1;
    htrans = 2'b10;
    hwrite = 1'b0;
    hsize  = size;
    haddr  = a;
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = 2'b00;
    wait_ready();
    data = smc_hrdata; // Valid while ready is high
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic check_reset_state();
    int start_errors;
    start_errors = error_count;
    compare_bit("smc_hready", smc_hready, 1'b1);
    compare_bit("smc_n_cs", smc_n_cs, 1'b1);
    compare_bit("smc_n_rd", smc_n_rd, 1'b1);
    compare_bit("smc_n_wr", smc_n_wr, 1'b1);
    compare_bit("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
    compare_bit("smc_n_we[0]", smc_n_we[0], 1'b1);
    compare_bit("smc_n_we[1]", smc_n_we[1], 1'b1);
    compare_bit("smc_n_be[0]", smc_n_be[0], 1'b1);
    compare_bit("smc_n_be[1]", smc_n_be[1], 1'b1);
    compare_bit("smc_busy", smc_busy, 1'b0);
    report_test("reset_state", start_errors);
  endtask

  task automatic word_write_read();
    int     start_errors;
    haddr_t a;
    hdata_t wdata;
    hdata_t rdata;
    start_errors = error_count;
    a     = 32'h0000_0040;
    wdata = 32'hCAFE_1234;
    ahb_write(a, `SMC_SIZE_WORD, wdata);
    shadow_write(a, `SMC_SIZE_WORD, wdata);
    compare_half("sram[A]", sram[a[8:1]], wdata[15:0]);
    compare_half("sram[A+2]", sram[a[8:1] + 1], wdata[31:16]);
    ahb_read(a, `SMC_SIZE_WORD, rdata);
    compare_data("smc_hrdata", rdata, wdata);
    report_test("word_write_read", start_errors);
  endtask

  task automatic byte_lane_writes();
    int         start_errors;
    haddr_t     base;
    haddr_t     a;
    logic [7:0] bytes_in [4];
    hdata_t     rdata;
    start_errors = error_count;
    base = 32'h0000_0080;
    for (int k = 0; k < 4; k++) begin
      bytes_in[k] = 8'($urandom);
      a = base + haddr_t'(k);
      ahb_write(a, `SMC_SIZE_BYTE, bus_lanes(a, `SMC_SIZE_BYTE, hdata_t'(bytes_in[k])));
      shadow_write(a, `SMC_SIZE_BYTE, bus_lanes(a, `SMC_SIZE_BYTE, hdata_t'(bytes_in[k])));
      compare_half("sram[base]", sram[base[8:1]], shadow[base[8:1]]);     // Other byte kept
      compare_half("sram[base+2]", sram[base[8:1] + 1], shadow[base[8:1] + 1]);
      // Only the addressed byte of the halfword enabled
      compare_bit("smc_n_be[0]", strobe_be[0], a[0] != 1'b0);
      compare_bit("smc_n_be[1]", strobe_be[1], a[0] != 1'b1);
    end
    ahb_read(base, `SMC_SIZE_WORD, rdata);
    compare_data("smc_hrdata", rdata, {bytes_in[3], bytes_in[2], bytes_in[1], bytes_in[0]});
    report_test("byte_lane_writes", start_errors);
  endtask

  task automatic halfword_read();
    int     start_errors;
    haddr_t a;
    hdata_t rdata;
    start_errors = error_count;
    a = 32'h0000_0100; // Untouched, still preloaded
    ahb_read(a, `SMC_SIZE_HALF, rdata);
    compare_data("smc_hrdata", rdata, {16'h0000, fill_value(int'(a[8:1]))});
    ahb_read(a + 2, `SMC_SIZE_HALF, rdata); // Upper lanes
    compare_data("smc_hrdata", rdata, {fill_value(int'(a[8:1]) + 1), 16'h0000});
    report_test("halfword_read", start_errors);
  endtask

  task automatic random_pairs();
    int         start_errors;
    logic       is_word;
    logic [2:0] size;
    haddr_t     a;
    hdata_t     lanes;
    hdata_t     rdata;
    start_errors = error_count;
    for (int n = 0; n < RAND_PAIRS; n++) begin
      is_word = 1'($urandom_range(1, 0));
      size    = is_word ? 3'(`SMC_SIZE_WORD) : 3'(`SMC_SIZE_HALF);
      a       = haddr_t'($urandom_range(SRAM_WORDS * 2 - 1, 0));
      a       = is_word ? (a & ~32'h3) : (a & ~32'h1); // Natural alignment
      lanes   = bus_lanes(a, size, hdata_t'($urandom));
      ahb_write(a, size, lanes);
      shadow_write(a, size, lanes);
      ahb_read(a, size, rdata);
      compare_data("smc_hrdata", rdata, expected_read(a, size));
    end
    report_test("random_pairs", start_errors);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    rst_n  = 1'b0;
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hsize  = 3'd0;
    haddr  = '0;
    hwdata = '0;
    hready = 1'b1; // Single slave, bus always ready
    void'($urandom(RNG_SEED));
    for (int i = 0; i < SRAM_WORDS; i++) begin
      sram[i]   = fill_value(i);
      shadow[i] = fill_value(i);
    end
    repeat (RST_CYCLES) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);

    check_reset_state();
    word_write_read();
    byte_lane_writes();
    halfword_read();
    random_pairs();

    $display("summary: %0d of %0d tests ok, %0d not ok, %0d check errors, %0d assertion errors",
             tests_ok, NUM_TESTS, tests_bad, error_count, UUT.u_smc_checker.violation_count);
    if (error_count == 0 && UUT.u_smc_checker.violation_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
smc_pkg.sv
smc_ahb_if.sv
smc_counter.sv
smc_state.sv
smc_mac.sv
smc_emi.sv
smc_lite.sv
smc_checker.sv
tb_smc_lite.sv
